/* files.f */
common/obj_pkg.sv
logic/obj_attr_fetch.sv
logic/affine_param_fetch.sv
obj_render/obj_render_unit.sv
obj_render/obj_line_buffer.sv
logic/obj_top.sv
tests/obj_assertions.sv
tests/obj_checker.sv
tests/obj_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module obj_tb -f files.f \
    -o obj_sim > build.log 2>&1 && ./obj_dir/obj_sim > sim.log 2>&1 || echo "build or run error"
grep -q "^SIMULATION PASSED$" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1

/* tests/obj_tb.sv */
`default_nettype none

module obj_tb
    import obj_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_tests      = 6;
    localparam int timeout_cycles = (num_tests * 3 + 4) * 1232;

    logic        clock, reset, obj_1d;
    logic [7:0]  vcount, hcount;
    logic [31:0] oam_data;
    logic [15:0] vram_data;
    logic [8:0]  oam_addr;
    logic [14:0] vram_addr;
    logic [19:0] obj_packet, expected;
    logic        check_en, first;
    logic [31:0] oam [512];
    logic [15:0] vram [32768];
    logic [19:0] exp_row [240];
    logic [31:0] rng_state;
    int          hpos, line_no, check_line, error_count, check_count;
    string       test_names [num_tests] = '{"regular 4bpp 1d", "flips", "overlap",
                                            "affine", "8bpp 2d", "hidden"};

    obj_top dut_i (.*);

    obj_checker checker_i (
        .clock, .reset, .check_en, .hcount, .expected, .obj_packet, .error_count, .check_count
    );

    bind obj_render_unit obj_assertions assertions_i (
        .clock, .reset, .state, .attr_valid, .param_start, .param_done, .clearing,
        .lb_we, .lb_col
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        #(timeout_cycles * 40);
        $display("watchdog expired after %0d cycles without the tests finishing", timeout_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    // one read cycle of latency on both memories
    always @(posedge clock) begin
        oam_data  <= oam[oam_addr];
        vram_data <= vram[vram_addr];
    end

    // mirrors the line timer, restarting on the first cycle after reset
    always @(posedge clock, posedge reset) begin
        if (reset) begin
            hpos    <= 0;
            line_no <= 0;
            first   <= 1'b1;
        end else begin
            first <= 1'b0;
            if (first || hpos == 1231) begin
                hpos    <= 0;
                line_no <= line_no + 1;
            end else begin
                hpos <= hpos + 1;
            end
        end
    end

    always @(negedge clock) begin
        vcount   <= 8'(line_no);
        hcount   <= (hpos < 256) ? 8'(hpos) : 8'd255;
        check_en <= (line_no == check_line) && (hpos < 240);
        expected <= exp_row[(hpos < 240) ? hpos : 0];
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rnd(int n);
        rng_state = xorshift(rng_state);
        return int'(rng_state[15:0]) % n;
    endfunction

    function automatic int tiles(logic [1:0] shape, logic [1:0] size, bit height);
        int wide [4] = '{2, 4, 4, 8};
        int tall [4] = '{1, 1, 2, 4};
        if (shape == 0)
            return 1 << size;
        if (shape == 3)
            return 1;
        return ((shape == 1) != height) ? wide[size] : tall[size];
    endfunction

    // expected packet from the OAM image, first opaque object in OAM order wins
    function automatic logic [19:0] ref_packet(int col, int row);
        logic [31:0] a0, a1;
        logic        aff, bpp;
        logic [15:0] hw;
        int w, h, bw, bh, dy, c, tx, ty, cx, cy, sx, sy, grp, off, tidx, addr, idx;
        for (int i = 0; i < 128; i++) begin
            a0  = oam[2 * i];
            a1  = oam[2 * i + 1];
            aff = a0[8];
            bpp = a0[13];
            if ((!aff && a0[9]) || a0[11:10] == 2'd3)
                continue;
            w  = 8 * tiles(a0[15:14], a0[31:30], 0);
            h  = 8 * tiles(a0[15:14], a0[31:30], 1);
            bw = (aff && a0[9]) ? 2 * w : w;
            bh = (aff && a0[9]) ? 2 * h : h;
            dy = (row - int'(a0[7:0])) & 255;
            c  = (col - int'(a0[24:16])) & 511;
            if (dy >= bh || c >= bw)
                continue;
            if (aff) begin
                grp = a0[29:25];
                cx  = c - bw / 2;
                cy  = dy - bh / 2;
                sx  = $signed(oam[8 * grp + 1][31:16]) * cx + $signed(oam[8 * grp + 3][31:16]) * cy;
                sy  = $signed(oam[8 * grp + 5][31:16]) * cx + $signed(oam[8 * grp + 7][31:16]) * cy;
                tx  = (sx >>> 8) + w / 2;
                ty  = (sy >>> 8) + h / 2;
                if (tx < 0 || tx >= w || ty < 0 || ty >= h)
                    continue;
            end else begin
                tx = a0[28] ? w - 1 - c : c;
                ty = a0[29] ? h - 1 - dy : dy;
            end
            if (obj_1d)
                off = ((ty / 8) * (w / 8) + tx / 8) << bpp;
            else
                off = (ty / 8) * 32 + ((tx / 8) << bpp);
            tidx = (int'(a1[9:0]) + off) & 2047;
            addr = bpp ? tidx * 16 + (ty % 8) * 4 + (tx % 8) / 2
                       : tidx * 16 + (ty % 8) * 2 + (tx % 8) / 4;
            hw   = vram[addr & 32767];
            idx  = bpp ? (tx[0] ? hw[15:8] : hw[7:0]) : hw[4 * (tx % 4) +: 4];
            if (idx != 0)
                return {1'b1, a1[11:10], a0[11:10], bpp, 2'b00, bpp ? 4'h0 : a1[15:12], 8'(idx)};
        end
        return '0;
    endfunction

    task automatic regular_obj(int i, int x, int y, int shape, int size, int tile, int bpp,
                               int hf, int vf, int mode, int hide);
        oam[2 * i] = {2'(size), 1'(vf), 1'(hf), 3'b000, 9'(x), 2'(shape), 1'(bpp), 1'b0,
                      2'(mode), 1'(hide), 1'b0, 8'(y)};
        oam[2 * i + 1][15:0] = {4'(rnd(16)), 2'(rnd(4)), 10'(tile)};
    endtask

    task automatic affine_obj(int i, int x, int y, int size, int dbl, int grp);
        oam[2 * i] = {2'(size), 5'(grp), 9'(x), 2'b00, 2'b00, 2'b00, 1'(dbl), 1'b1, 8'(y)};
        oam[2 * i + 1][15:0] = {4'(rnd(16)), 2'(rnd(4)), 10'(rnd(512))};
    endtask

    task automatic set_matrix(int grp, int pa, int pb, int pc, int pd);
        oam[8 * grp + 1][31:16] = 16'(pa);
        oam[8 * grp + 3][31:16] = 16'(pb);
        oam[8 * grp + 5][31:16] = 16'(pc);
        oam[8 * grp + 7][31:16] = 16'(pd);
    endtask

    task automatic load_scene(int t, int row);
        for (int i = 0; i < 128; i++) begin
            oam[2 * i]     = 32'h0000_0200;  // regular sprite with the hide bit
            oam[2 * i + 1] = '0;
        end
        obj_1d = (t == 2 || t == 4) ? 1'b0 : 1'b1;
        case (t)
            0: regular_obj(0, 20 + rnd(120), row - rnd(16), 0, 1, rnd(512), 0, 0, 0, 0, 0);
            1: begin
                regular_obj(0, 30, row - rnd(32), 2, 2, rnd(512), 0, 1, 1, 0, 0);
                regular_obj(1, 120, row - rnd(8), 1, 1, rnd(512), 0, 1, 0, 1, 0);
            end
            2: begin
                regular_obj(0, 60, row - 4, 0, 1, rnd(512), 0, 0, 0, 0, 0);
                regular_obj(1, 68, row - 9, 0, 1, rnd(512), 0, 0, 1, 2, 0);
                regular_obj(2, 50, row - 12, 0, 2, rnd(512), 0, 1, 0, 0, 0);
            end
            3: begin
                set_matrix(30, 256, 0, 0, 256);
                set_matrix(31, 128, 0, 0, 128);  // magnifies twice
                affine_obj(0, 10, row - 8, 1, 0, 30);
                affine_obj(1, 50, row - 8, 1, 1, 30);
                affine_obj(2, 100, row - 8, 1, 0, 31);
                affine_obj(3, 150, row - 8, 1, 1, 31);
            end
            4: begin
                regular_obj(0, 40 + rnd(60), row - rnd(16), 0, 1, 2 * rnd(256), 1, 0, 0, 0, 0);
                regular_obj(1, 150, row - rnd(8), 1, 0, 2 * rnd(256), 1, 1, 0, 0, 0);
            end
            default: begin
                regular_obj(0, 40, row - 2, 0, 1, rnd(512), 0, 0, 0, 3, 0);
                regular_obj(1, 100, row - 2, 0, 1, rnd(512), 0, 0, 0, 0, 1);
                regular_obj(2, 244, row - 2, 0, 1, rnd(512), 0, 0, 0, 0, 0);
            end
        endcase
    endtask

    task automatic wait_line();
        int l;
        l = line_no;
        do @(negedge clock); while (line_no == l);
    endtask

    initial begin
        int row, e0, c0;
        reset      = 1'b1;
        obj_1d     = 1'b1;
        vcount     = '0;
        hcount     = '0;
        oam_data   = '0;
        vram_data  = '0;
        check_en   = 1'b0;
        expected   = '0;
        check_line = -1;
        rng_state  = 32'd60;
        for (int a = 0; a < 32768; a++)
            vram[a] = 16'((a * 40503 + 4660) ^ (a >> 7));  // nibble zeros give holes
        for (int a = 0; a < 512; a++)
            oam[a] = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        wait_line();
        for (int t = 0; t < num_tests; t++) begin
            row = (line_no + 2) % 256;
            load_scene(t, row);
            for (int col = 0; col < 240; col++)
                exp_row[col] = ref_packet(col, row);
            check_line = line_no + 2;  // the next line is rendered from a clean scene
            e0 = error_count;
            c0 = check_count;
            repeat (3) wait_line();
            $display("test %0d %s: %0d columns, %0d errors", t, test_names[t],
                     check_count - c0, error_count - e0);
        end
        $display("tests %0d, columns checked %0d, errors %0d", num_tests, check_count, error_count);
        if (error_count == 0 && check_count == num_tests * 240) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/obj_checker.sv */
`default_nettype none

module obj_checker
    import obj_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    check_en,
    input  logic [7:0]              hcount,
    input  logic [packet_width-1:0] expected,
    input  logic [packet_width-1:0] obj_packet,
    output int                      error_count,
    output int                      check_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // inputs change on the falling edge so the rising edge sees settled values
    always @(posedge clock, posedge reset) begin
        if (reset) begin
            error_count <= 0;
            check_count <= 0;
        end else if (check_en) begin
            check_count <= check_count + 1;
            if (obj_packet !== expected) begin
                $display("[ERROR] obj_packet column %0d: expected %05h, got %05h",
                         hcount, expected, obj_packet);
                error_count <= error_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/obj_assertions.sv */
`default_nettype none

module obj_assertions
    import obj_pkg::*;
(
    input logic          clock,
    input logic          reset,
    input render_state_e state,
    input logic          attr_valid,
    input logic          param_start,
    input logic          param_done,
    input logic          clearing,
    input logic          lb_we,
    input logic [7:0]    lb_col
);
    timeunit 1ns;
    timeprecision 1ps;

    // the matrix arrives while the FSM is still parked in rs_affine
    affine_fetch_time: assert property (@(posedge clock) disable iff (reset)
        param_start |-> ##5 (param_done && state == rs_affine))
        else $error("param_done missing five cycles after param_start");

    // the pipeline tail must not reach the row that is being wiped
    write_on_screen: assert property (@(posedge clock) disable iff (reset)
        lb_we |-> (lb_col < 8'(screen_width)) && !clearing)
        else $error("line buffer write to column %0d off screen or during the wipe", lb_col);

    // the OAM port cannot serve a new object and a matrix fetch at once
    single_oam_user: assert property (@(posedge clock) disable iff (reset)
        param_start |-> attr_valid)
        else $error("param_start while the attribute fetch still reads OAM");

endmodule

`default_nettype wire

/* logic/obj_top.sv */
`default_nettype none

module obj_top
    import obj_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    obj_1d,
    input  logic [7:0]              vcount,
    input  logic [7:0]              hcount,
    input  logic [31:0]             oam_data,
    input  logic [15:0]             vram_data,
    output logic [8:0]              oam_addr,
    output logic [14:0]             vram_addr,
    output logic [packet_width-1:0] obj_packet
);

    logic [8:0]  attr_addr, obj_x;
    logic [7:0]  obj_y, lb_col;
    logic [1:0]  obj_shape, obj_size, obj_priority;
    logic [4:0]  affine_index;
    logic [9:0]  tile_num;
    logic [3:0]  palette_bank;
    logic [15:0] pa, pb, pc, pd;
    logic        attr_valid, h_flip, v_flip, affine_en, double_size, eight_bpp, last_obj;
    logic        line_start, next_obj, param_start, param_done, lb_we;
    obj_mode_e   mode;
    logic [packet_width-1:0] lb_packet;

    obj_attr_fetch attr_fetch (
        .clock, .reset, .line_start, .next_obj, .oam_data, .attr_addr, .attr_valid,
        .obj_x, .obj_y, .obj_shape, .obj_size, .h_flip, .v_flip, .affine_en, .double_size,
        .affine_index, .tile_num, .obj_priority, .palette_bank, .eight_bpp, .mode, .last_obj
    );

    affine_param_fetch param_fetch (
        .clock, .reset, .param_start, .affine_index, .attr_addr, .oam_data,
        .oam_addr, .param_done, .pa, .pb, .pc, .pd
    );

    obj_render_unit render (
        .clock, .reset, .obj_1d, .vcount, .attr_valid, .obj_x, .obj_y, .obj_shape,
        .obj_size, .h_flip, .v_flip, .affine_en, .double_size, .tile_num, .obj_priority,
        .palette_bank, .eight_bpp, .mode, .last_obj, .param_done, .pa, .pb, .pc, .pd,
        .vram_data, .line_start, .next_obj, .param_start, .vram_addr, .lb_we, .lb_col,
        .lb_packet
    );

    obj_line_buffer line_buffer (
        .clock, .reset, .line_start,
        .we(lb_we), .wcol(lb_col), .wpacket(lb_packet),
        .hcount, .obj_packet
    );

endmodule

`default_nettype wire

/* obj_render/obj_line_buffer.sv */
`default_nettype none

module obj_line_buffer
    import obj_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    line_start,
    input  logic                    we,
    input  logic [7:0]              wcol,
    input  logic [packet_width-1:0] wpacket,
    input  logic [7:0]              hcount,
    output logic [packet_width-1:0] obj_packet
);

    logic [packet_width-1:0] rows [2][screen_width];
    logic                    sel;        // store shown on the current line
    logic                    front_ok;   // front row was wiped before it was drawn
    logic                    cleared;
    logic [7:0]              clr_col;
    logic                    clearing;
    logic [packet_width-1:0] back_entry;

    assign clearing   = clr_col < 8'(screen_width);
    assign back_entry = rows[!sel][wcol];
    assign obj_packet = (front_ok && hcount < 8'(screen_width)) ? rows[sel][hcount] : '0;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sel      <= 1'b0;
            front_ok <= 1'b0;
            cleared  <= 1'b0;
            clr_col  <= 8'(screen_width);
        end else if (line_start) begin
            sel      <= !sel;
            front_ok <= cleared;
            cleared  <= 1'b0;
            clr_col  <= 8'd0;
        end else if (clearing) begin
            clr_col <= clr_col + 8'd1;
            if (clr_col == 8'(screen_width - 1))
                cleared <= 1'b1;
        end
    end

    // objects arrive in OAM order so an opaque entry already belongs to a lower index
    always_ff @(posedge clock) begin
        if (clearing)
            rows[!sel][clr_col] <= '0;
        else if (we && !back_entry[pkt_opaque_bit])
            rows[!sel][wcol] <= wpacket;
    end

endmodule

`default_nettype wire

/* obj_render/obj_render_unit.sv */
`default_nettype none

module obj_render_unit
    import obj_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        obj_1d,
    input  logic [7:0]  vcount,
    input  logic        attr_valid,
    input  logic [8:0]  obj_x,
    input  logic [7:0]  obj_y,
    input  logic [1:0]  obj_shape,
    input  logic [1:0]  obj_size,
    input  logic        h_flip,
    input  logic        v_flip,
    input  logic        affine_en,
    input  logic        double_size,
    input  logic [9:0]  tile_num,
    input  logic [1:0]  obj_priority,
    input  logic [3:0]  palette_bank,
    input  logic        eight_bpp,
    input  obj_mode_e   mode,
    input  logic        last_obj,
    input  logic        param_done,
    input  logic [15:0] pa,
    input  logic [15:0] pb,
    input  logic [15:0] pc,
    input  logic [15:0] pd,
    input  logic [15:0] vram_data,
    output logic        line_start,
    output logic        next_obj,
    output logic        param_start,
    output logic [14:0] vram_addr,
    output logic        lb_we,
    output logic [7:0]  lb_col,
    output logic [packet_width-1:0] lb_packet
);

    render_state_e state, state_next;
    logic [10:0] timer;
    logic        first_cycle;
    logic        clearing, late, issue;
    logic [6:0]  col_offset;
    logic [6:0]  w_px, h_px;
    logic [7:0]  bound_w, bound_h;
    logic [7:0]  dy;
    logic        visible;
    logic [8:0]  screen_col;
    logic signed [8:0]  cx, cy;
    logic signed [25:0] sum_x, sum_y;
    logic signed [17:0] aff_x, aff_y;
    logic        outside;
    logic [5:0]  tex_x, tex_y;
    logic [10:0] tile_off, tile_idx;
    logic [4:0]  in_tile;
    logic        p1_valid, p1_clip, p1_8bpp;
    logic [7:0]  p1_col;
    logic [1:0]  p1_sel, p1_pri;
    obj_mode_e   p1_mode;
    logic [3:0]  p1_pal;
    logic [7:0]  texel;
    logic [packet_width-1:0] packet;

    assign line_start = first_cycle || (timer == 11'(line_cycles - 1));
    assign clearing   = timer < 11'(screen_width);      // line buffer is still wiping its back row
    assign late       = timer >= 11'(line_cycles - 8);  // a matrix fetch would spill into the next line

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            timer       <= '0;
            first_cycle <= 1'b1;
        end else begin
            first_cycle <= 1'b0;
            timer       <= line_start ? 11'd0 : timer + 11'd1;
        end
    end

    assign w_px       = {obj_width_tiles[obj_shape][obj_size], 3'b000};
    assign h_px       = {obj_height_tiles[obj_shape][obj_size], 3'b000};
    assign bound_w    = double_size ? {w_px, 1'b0} : {1'b0, w_px};
    assign bound_h    = double_size ? {h_px, 1'b0} : {1'b0, h_px};
    assign dy         = vcount + 8'd1 - obj_y;  // the row below the one on screen
    assign visible    = (mode != mode_disabled) && (dy < bound_h);
    assign screen_col = obj_x + {2'b00, col_offset};

    // offset from the centre of the bounding box, rotated back into texture space
    assign cx    = $signed({2'b00, col_offset}) - $signed({2'b00, bound_w[7:1]});
    assign cy    = $signed({1'b0, dy}) - $signed({2'b00, bound_h[7:1]});
    assign sum_x = $signed(pa) * cx + $signed(pb) * cy;
    assign sum_y = $signed(pc) * cx + $signed(pd) * cy;
    assign aff_x = $signed(sum_x[25:affine_frac_bits]) + $signed({12'b0, w_px[6:1]});
    assign aff_y = $signed(sum_y[25:affine_frac_bits]) + $signed({12'b0, h_px[6:1]});
    assign outside = aff_x[17] || (aff_x[16:0] >= 17'(w_px))
                  || aff_y[17] || (aff_y[16:0] >= 17'(h_px));

    always_comb begin
        if (affine_en) begin
            tex_x = aff_x[5:0];
            tex_y = aff_y[5:0];
        end else begin
            tex_x = h_flip ? 6'(w_px - 7'd1 - col_offset) : col_offset[5:0];
            tex_y = v_flip ? 6'(h_px - 7'd1 - dy[6:0]) : dy[5:0];
        end
        if (obj_1d)
            tile_off = (11'(tex_y[5:3]) * 11'(obj_width_tiles[obj_shape][obj_size])
                       + 11'(tex_x[5:3])) << eight_bpp;
        else
            tile_off = {3'b000, tex_y[5:3], 5'b00000} + (11'(tex_x[5:3]) << eight_bpp);
    end

    assign tile_idx  = {1'b0, tile_num} + tile_off;
    assign in_tile   = eight_bpp ? {tex_y[2:0], tex_x[2:1]} : {1'b0, tex_y[2:0], tex_x[2]};
    assign vram_addr = {tile_idx, 4'b0000} + {10'b0, in_tile};

    always_comb begin
        state_next  = state;
        next_obj    = 1'b0;
        param_start = 1'b0;
        issue       = 1'b0;
        if (line_start) begin
            state_next = rs_fetch;  // whatever is left of the old line is dropped
        end else begin
            case (state)
                rs_idle: state_next = rs_idle;
                rs_fetch: begin
                    if (attr_valid)
                        state_next = rs_wait;
                end
                rs_wait: begin
                    if (!visible) begin
                        next_obj   = !last_obj;
                        state_next = last_obj ? rs_idle : rs_fetch;
                    end else if (!clearing && affine_en) begin
                        if (!late) begin
                            param_start = 1'b1;
                            state_next  = rs_affine;
                        end
                    end else if (!clearing) begin
                        state_next = rs_write;
                    end
                end
                rs_affine: begin
                    if (param_done)
                        state_next = rs_write;
                end
                rs_write: begin
                    issue = 1'b1;
                    if ({1'b0, col_offset} == bound_w - 8'd1) begin
                        next_obj   = !last_obj;
                        state_next = last_obj ? rs_idle : rs_fetch;
                    end
                end
                default: state_next = rs_idle;
            endcase
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state      <= rs_idle;
            col_offset <= '0;
            p1_valid   <= 1'b0;
            lb_we      <= 1'b0;
        end else begin
            state      <= state_next;
            col_offset <= (issue && state_next == rs_write) ? col_offset + 7'd1 : 7'd0;
            p1_valid   <= issue;
            lb_we      <= p1_valid && !p1_clip && (texel != 8'd0) && !line_start;
        end
    end

    // vram_data belongs to the pixel held in the p1 registers
    always_comb begin
        if (p1_8bpp)
            texel = p1_sel[0] ? vram_data[15:8] : vram_data[7:0];
        else
            texel = {4'b0000, vram_data[{p1_sel, 2'b00} +: 4]};
        packet = '0;
        packet[pkt_opaque_bit]     = 1'b1;
        packet[pkt_pri_lsb +: 2]   = p1_pri;
        packet[pkt_mode_lsb +: 2]  = p1_mode;
        packet[pkt_bpp_bit]        = p1_8bpp;
        packet[pkt_zero_lsb +: 2]  = 2'b00;
        packet[pkt_pal_lsb +: 4]   = p1_8bpp ? 4'h0 : p1_pal;  // 8bpp uses the whole palette
        packet[pkt_index_lsb +: 8] = texel;
    end

    always_ff @(posedge clock) begin
        p1_clip   <= (screen_col >= 9'(screen_width)) || (affine_en && outside);
        p1_col    <= screen_col[7:0];
        p1_sel    <= tex_x[1:0];
        p1_8bpp   <= eight_bpp;
        p1_pri    <= obj_priority;
        p1_mode   <= mode;
        p1_pal    <= palette_bank;
        lb_col    <= p1_col;
        lb_packet <= packet;
    end

endmodule

`default_nettype wire

/* logic/affine_param_fetch.sv */
`default_nettype none

module affine_param_fetch (
    input  logic        clock,
    input  logic        reset,
    input  logic        param_start,
    input  logic [4:0]  affine_index,
    input  logic [8:0]  attr_addr,
    input  logic [31:0] oam_data,
    output logic [8:0]  oam_addr,
    output logic        param_done,
    output logic [15:0] pa,
    output logic [15:0] pb,
    output logic [15:0] pc,
    output logic [15:0] pd
);

    logic       busy;
    logic [1:0] slot;
    logic       rd_valid;   // a matrix word is on oam_data this cycle
    logic [1:0] rd_slot;

    // group g keeps its matrix in the upper half of the second word of entries 4g to 4g+3
    assign oam_addr   = busy ? {1'b0, affine_index, slot, 1'b1} : attr_addr;
    assign param_done = rd_valid && (rd_slot == 2'd3);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            slot     <= '0;
            rd_valid <= 1'b0;
            rd_slot  <= '0;
        end else begin
            rd_valid <= busy;
            rd_slot  <= slot;
            if (param_start) begin
                busy <= 1'b1;
                slot <= 2'd0;
            end else if (busy) begin
                slot <= slot + 2'd1;
                if (slot == 2'd3)
                    busy <= 1'b0;
            end
        end
    end

    // pd lands on the edge that ends the param_done cycle
    always_ff @(posedge clock) begin
        if (rd_valid) begin
            case (rd_slot)
                2'd0: pa <= oam_data[31:16];
                2'd1: pb <= oam_data[31:16];
                2'd2: pc <= oam_data[31:16];
                default: pd <= oam_data[31:16];
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/obj_attr_fetch.sv */
`default_nettype none

module obj_attr_fetch
    import obj_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        line_start,
    input  logic        next_obj,
    input  logic [31:0] oam_data,
    output logic [8:0]  attr_addr,
    output logic        attr_valid,
    output logic [8:0]  obj_x,
    output logic [7:0]  obj_y,
    output logic [1:0]  obj_shape,
    output logic [1:0]  obj_size,
    output logic        h_flip,
    output logic        v_flip,
    output logic        affine_en,
    output logic        double_size,
    output logic [4:0]  affine_index,
    output logic [9:0]  tile_num,
    output logic [1:0]  obj_priority,
    output logic [3:0]  palette_bank,
    output logic        eight_bpp,
    output obj_mode_e   mode,
    output logic        last_obj
);

    logic [6:0] obj_index;
    logic [1:0] phase;  // 0 and 1 address the two words, 2 takes the second, 3 is idle

    assign attr_addr = {1'b0, obj_index, phase[0]};
    assign last_obj  = (obj_index == 7'(obj_count - 1));

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            obj_index  <= '0;
            phase      <= 2'd3;
            attr_valid <= 1'b0;
        end else if (line_start || next_obj) begin
            obj_index  <= line_start ? 7'd0 : obj_index + 7'd1;
            phase      <= 2'd0;
            attr_valid <= 1'b0;
        end else if (phase != 2'd3) begin
            phase      <= phase + 2'd1;
            attr_valid <= (phase == 2'd2);  // fields complete once the second word is in
        end
    end

    // first word holds attr0 in the low half and attr1 in the high half
    always_ff @(posedge clock) begin
        if (phase == 2'd1) begin
            obj_y        <= oam_data[7:0];
            affine_en    <= oam_data[attr_affine_bit];
            double_size  <= oam_data[attr_affine_bit] & oam_data[attr_hide_bit];
            eight_bpp    <= oam_data[attr_bpp_bit];
            obj_shape    <= oam_data[15:14];
            obj_x        <= oam_data[24:16];
            affine_index <= oam_data[29:25];
            h_flip       <= oam_data[attr_hflip_bit];
            v_flip       <= oam_data[attr_vflip_bit];
            obj_size     <= oam_data[31:30];
            // the hide bit only means hidden on a regular sprite
            if (!oam_data[attr_affine_bit] && oam_data[attr_hide_bit])
                mode <= mode_disabled;
            else
                mode <= obj_mode_e'(oam_data[11:10]);
        end
        if (phase == 2'd2) begin
            tile_num     <= oam_data[9:0];
            obj_priority <= oam_data[11:10];
            palette_bank <= oam_data[15:12];
        end
    end

endmodule

`default_nettype wire

/* common/obj_pkg.sv */
`default_nettype none

package obj_pkg;

    // scan line timing and screen geometry
    localparam int line_cycles  = 1232;
    localparam int screen_width = 240;
    localparam int obj_count    = 128;

    // pixel packet layout, an all zero packet is transparent
    localparam int packet_width   = 20;
    localparam int pkt_opaque_bit = 19;
    localparam int pkt_pri_lsb    = 17;  // two bits
    localparam int pkt_mode_lsb   = 15;  // two bits
    localparam int pkt_bpp_bit    = 14;
    localparam int pkt_zero_lsb   = 12;  // two bits, always zero
    localparam int pkt_pal_lsb    = 8;   // four bits
    localparam int pkt_index_lsb  = 0;   // eight bits

    // single bit fields of the first OAM word of an entry
    localparam int attr_affine_bit = 8;
    localparam int attr_hide_bit   = 9;   // double size when the affine bit is set
    localparam int attr_bpp_bit    = 13;
    localparam int attr_hflip_bit  = 28;
    localparam int attr_vflip_bit  = 29;

    localparam int affine_frac_bits = 8;

    typedef enum logic [1:0] {
        mode_normal   = 2'd0,
        mode_semi     = 2'd1,
        mode_window   = 2'd2,
        mode_disabled = 2'd3
    } obj_mode_e;

    typedef enum logic [2:0] {
        rs_idle   = 3'd0,
        rs_fetch  = 3'd1,
        rs_wait   = 3'd2,
        rs_affine = 3'd3,
        rs_write  = 3'd4
    } render_state_e;

    // sprite size in 8 pixel tiles, indexed by shape then size code
    // shape 3 is not a legal shape and falls back to a single tile
    localparam logic [3:0] obj_width_tiles [4][4] = '{
        '{4'd1, 4'd2, 4'd4, 4'd8},
        '{4'd2, 4'd4, 4'd4, 4'd8},
        '{4'd1, 4'd1, 4'd2, 4'd4},
        '{4'd1, 4'd1, 4'd1, 4'd1}
    };

    localparam logic [3:0] obj_height_tiles [4][4] = '{
        '{4'd1, 4'd2, 4'd4, 4'd8},
        '{4'd1, 4'd1, 4'd2, 4'd4},
        '{4'd2, 4'd4, 4'd4, 4'd8},
        '{4'd1, 4'd1, 4'd1, 4'd1}
    };

endpackage

`default_nettype wire
